//--- lcd_timing_pkg.sv
package lcd_timing_pkg;

	// 25 MHz system clock
	localparam int cycles_per_us = 25;

	// wait after power is applied
	localparam int powerup_cycles = 500 * cycles_per_us;

	// e high time for each init command
	localparam int cmd_pulse_cycles = 10 * cycles_per_us;

	// settle after function set, on/off and every host command
	localparam int wait_short_cycles = 50 * cycles_per_us;

	// display clear needs the longest settle
	localparam int wait_clear_cycles = 200 * cycles_per_us;
	localparam int wait_entry_cycles = 100 * cycles_per_us;

	// host command enable window, measured from the pop cycle
	localparam int setup_cycles      = 1 * cycles_per_us;
	localparam int pulse_high_cycles = 13 * cycles_per_us;

	// must hold powerup_cycles
	localparam int cnt_width = 15;

endpackage

//--- lcd_regs_pkg.sv
package lcd_regs_pkg;

	// register byte offsets
	localparam logic [3:0] addr_config = 4'h0;
	localparam logic [3:0] addr_cmd    = 4'h4;
	localparam logic [3:0] addr_status = 4'h8;

	// {two_lines, font, display_on, cursor, blink, increment, shift}
	localparam int cfg_width = 7;

	// {rs, rw, data[7:0]}
	localparam int cmd_width = 10;

	localparam int fifo_depth  = 8;
	localparam int level_width = 4;   // holds 0..fifo_depth

	typedef enum logic [1:0] {power_up, init, idle, pulse} ctrl_state_e;

	typedef enum logic [1:0] {function_set, on_off, clear, entry_mode} init_step_e;

	typedef enum logic {wr_idle, wr_resp} axil_wr_state_e;

	typedef enum logic {rd_idle, rd_data} axil_rd_state_e;

	localparam logic [1:0] axil_resp_okay   = 2'b00;
	localparam logic [1:0] axil_resp_slverr = 2'b10;

endpackage

//--- lcd_axil_regs.sv
module lcd_axil_regs (
	input  logic                                clk,
	input  logic                                arst_n,
	input  logic [3:0]                          awaddr,
	input  logic                                awvalid,
	output logic                                awready,
	input  logic [31:0]                         wdata,
	input  logic [3:0]                          wstrb,
	input  logic                                wvalid,
	output logic                                wready,
	output logic [1:0]                          bresp,
	output logic                                bvalid,
	input  logic                                bready,
	input  logic [3:0]                          araddr,
	input  logic                                arvalid,
	output logic                                arready,
	output logic [31:0]                         rdata,
	output logic [1:0]                          rresp,
	output logic                                rvalid,
	input  logic                                rready,
	input  logic                                full,
	input  logic [lcd_regs_pkg::level_width-1:0] level,
	input  logic                                busy,
	input  logic                                init_done,
	output logic [lcd_regs_pkg::cfg_width-1:0]  cfg,
	output logic                                push,
	output logic [lcd_regs_pkg::cmd_width-1:0]  push_data
);

	import lcd_regs_pkg::*;

	axil_wr_state_e wr_state;
	axil_rd_state_e rd_state;

	// write channel, address and data are taken together
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_state <= wr_idle;
			awready  <= 1'b0;
			wready   <= 1'b0;
			bvalid   <= 1'b0;
			bresp    <= axil_resp_okay;
			push     <= 1'b0;
			cfg      <= '0;
		end else begin
			push <= 1'b0;   // single-cycle strobe
			case (wr_state)
				wr_idle: begin
					if (awready) begin   // handshake cycle
						awready  <= 1'b0;
						wready   <= 1'b0;
						bvalid   <= 1'b1;
						wr_state <= wr_resp;
						case (awaddr)
							addr_config: begin
								if (wstrb[0])
									cfg <= wdata[cfg_width-1:0];
								bresp <= axil_resp_okay;
							end
							addr_cmd: begin
								if (full) begin
									bresp <= axil_resp_slverr;   // dropped
								end else begin
									push  <= 1'b1;
									bresp <= axil_resp_okay;
								end
							end
							default: bresp <= axil_resp_slverr;   // status is read only
						endcase
					end else if (awvalid && wvalid) begin
						awready <= 1'b1;
						wready  <= 1'b1;
					end
				end
				wr_resp: begin
					if (bready) begin
						bvalid   <= 1'b0;
						wr_state <= wr_idle;
					end
				end
				default: wr_state <= wr_idle;
			endcase
		end
	end

	// command payload, qualified by push
	always_ff @(posedge clk) begin
		if (wr_state == wr_idle && awready)
			push_data <= wdata[cmd_width-1:0];
	end

	// read channel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_state <= rd_idle;
			arready  <= 1'b0;
			rvalid   <= 1'b0;
		end else begin
			case (rd_state)
				rd_idle: begin
					if (arready) begin
						arready  <= 1'b0;
						rvalid   <= 1'b1;
						rd_state <= rd_data;
					end else if (arvalid) begin
						arready <= 1'b1;
					end
				end
				rd_data: begin
					if (rready) begin
						rvalid   <= 1'b0;
						rd_state <= rd_idle;
					end
				end
				default: rd_state <= rd_idle;
			endcase
		end
	end

	// read payload, sampled at the address handshake
	always_ff @(posedge clk) begin
		if (rd_state == rd_idle && arready) begin
			case (araddr)
				addr_config: begin
					rdata <= {{(32 - cfg_width){1'b0}}, cfg};
					rresp <= axil_resp_okay;
				end
				addr_cmd: begin
					rdata <= '0;   // write-only port
					rresp <= axil_resp_okay;
				end
				addr_status: begin
					rdata <= {24'b0, level, 2'b00, init_done, busy};
					rresp <= axil_resp_okay;
				end
				default: begin
					rdata <= '0;
					rresp <= axil_resp_slverr;
				end
			endcase
		end
	end

endmodule

//--- lcd_cmd_fifo.sv
module lcd_cmd_fifo (
	input  logic                                 clk,
	input  logic                                 arst_n,
	input  logic                                 push,
	input  logic [lcd_regs_pkg::cmd_width-1:0]   push_data,
	input  logic                                 pop,
	output logic [lcd_regs_pkg::cmd_width-1:0]   pop_data,
	output logic                                 empty,
	output logic                                 full,
	output logic [lcd_regs_pkg::level_width-1:0] level
);

	import lcd_regs_pkg::*;

	logic [cmd_width-1:0]          mem [fifo_depth];
	logic [$clog2(fifo_depth)-1:0] wr_ptr;
	logic [$clog2(fifo_depth)-1:0] rd_ptr;
	logic [level_width-1:0]        count;
	logic                          do_push;
	logic                          do_pop;

	assign do_push = push && !full;   // refused writes never get here
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	assign pop_data = mem[rd_ptr];   // head word
	assign empty    = (count == '0);
	assign full     = (count == level_width'(fifo_depth));
	assign level    = count;

endmodule

//--- lcd_hd44780_ctrl.sv
module lcd_hd44780_ctrl (
	input  logic                               clk,
	input  logic                               arst_n,
	input  logic [lcd_regs_pkg::cfg_width-1:0] cfg,
	input  logic                               empty,
	input  logic [lcd_regs_pkg::cmd_width-1:0] pop_data,
	output logic                               pop,
	output logic                               busy,
	output logic                               init_done,
	output logic                               e,
	output logic                               rs,
	output logic                               rw,
	output logic [7:0]                         lcd_data
);

	import lcd_regs_pkg::*;
	import lcd_timing_pkg::*;

	ctrl_state_e           state;
	init_step_e            step;
	logic [cnt_width-1:0]  cnt;
	logic [cnt_width-1:0]  cnt_nxt;
	logic [cfg_width-1:0]  cfg_q;

	// command byte of an init step, built from the option bits
	function automatic logic [7:0] init_byte(input init_step_e s, input logic [cfg_width-1:0] c);
		case (s)
			function_set: return {4'b0011, c[6], c[5], 2'b00};
			on_off:       return {5'b00001, c[4], c[3], c[2]};
			clear:        return 8'h01;
			default:      return {6'b000001, c[1], c[0]};
		endcase
	endfunction

	// enable high plus settle, in cycles
	function automatic logic [cnt_width-1:0] step_len(input init_step_e s);
		case (s)
			clear:      return cnt_width'(cmd_pulse_cycles + wait_clear_cycles);
			entry_mode: return cnt_width'(cmd_pulse_cycles + wait_entry_cycles);
			default:    return cnt_width'(cmd_pulse_cycles + wait_short_cycles);
		endcase
	endfunction

	function automatic init_step_e step_after(input init_step_e s);
		case (s)
			function_set: return on_off;
			on_off:       return clear;
			default:      return entry_mode;
		endcase
	endfunction

	assign cnt_nxt = cnt + 1'b1;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= power_up;
			step      <= function_set;
			cnt       <= '0;
			cfg_q     <= '0;
			pop       <= 1'b0;
			busy      <= 1'b1;
			init_done <= 1'b0;
			e         <= 1'b0;
			rs        <= 1'b0;
			rw        <= 1'b0;
			lcd_data  <= '0;
		end else begin
			pop <= 1'b0;
			case (state)
				power_up: begin
					if (cnt == cnt_width'(powerup_cycles - 1)) begin
						cfg_q    <= cfg;   // options fixed for the whole sequence
						cnt      <= '0;
						step     <= function_set;
						e        <= 1'b1;
						lcd_data <= init_byte(function_set, cfg);
						state    <= init;
					end else begin
						cnt <= cnt_nxt;
					end
				end
				init: begin
					if (cnt == step_len(step) - 1'b1) begin
						cnt <= '0;
						if (step == entry_mode) begin
							e         <= 1'b0;
							lcd_data  <= '0;
							busy      <= 1'b0;
							init_done <= 1'b1;
							state     <= idle;
						end else begin
							step     <= step_after(step);   // next command, no gap
							e        <= 1'b1;
							lcd_data <= init_byte(step_after(step), cfg_q);
						end
					end else begin
						cnt <= cnt_nxt;
						// outputs for the coming cycle
						if (cnt_nxt < cnt_width'(cmd_pulse_cycles)) begin
							e        <= 1'b1;
							lcd_data <= init_byte(step, cfg_q);
						end else begin
							e        <= 1'b0;
							lcd_data <= '0;
						end
					end
				end
				idle: begin
					if (!empty) begin
						pop      <= 1'b1;
						busy     <= 1'b1;
						rs       <= pop_data[9];
						rw       <= pop_data[8];
						lcd_data <= pop_data[7:0];
						cnt      <= '0;
						state    <= pulse;
					end
				end
				pulse: begin
					if (cnt == cnt_width'(wait_short_cycles - 1)) begin
						cnt      <= '0;
						busy     <= 1'b0;
						e        <= 1'b0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= '0;
						state    <= idle;
					end else begin
						cnt <= cnt_nxt;
						// setup, then high, then low until settle ends
						e <= (cnt_nxt >= cnt_width'(setup_cycles)) &&
							(cnt_nxt < cnt_width'(setup_cycles + pulse_high_cycles));
					end
				end
				default: state <= power_up;
			endcase
		end
	end

endmodule

//--- lcd_subsystem_top.sv
module lcd_subsystem_top (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output logic        e,
	output logic        rs,
	output logic        rw,
	output logic [7:0]  lcd_data
);

	import lcd_regs_pkg::*;

	logic [cfg_width-1:0]   cfg;
	logic                   push;
	logic [cmd_width-1:0]   push_data;
	logic                   pop;
	logic [cmd_width-1:0]   pop_data;
	logic                   empty;
	logic                   full;
	logic [level_width-1:0] level;
	logic                   busy;
	logic                   init_done;

	lcd_axil_regs u_regs (.*);   // host side

	lcd_cmd_fifo u_fifo (.*);

	lcd_hd44780_ctrl u_ctrl (.*);   // drives the LCD pins

endmodule

//--- tb_lcd_checker.sv
module tb_lcd_checker (
	input logic        clk,
	input logic        arst_n,
	input logic        e,
	input logic        rs,
	input logic        rw,
	input logic [7:0]  lcd_data,
	input logic        bvalid,
	input logic        bready,
	input logic [1:0]  bresp,
	input logic        rvalid,
	input logic        rready,
	input logic [1:0]  rresp,
	input logic [31:0] rdata
);

	timeunit 1ns;
	timeprecision 1ps;

	import lcd_timing_pkg::*;

	int          value_errors = 0;
	int          pulse_errors = 0;
	string       pin_name[$];   // expected enable pulses, in order
	logic [9:0]  pin_word[$];
	int          pin_width[$];
	bit          pin_host[$];
	string       wr_name[$];
	logic [1:0]  wr_resp[$];
	string       rd_name[$];
	logic [1:0]  rd_resp[$];
	logic [31:0] rd_data[$];
	logic [31:0] rd_mask[$];
	int          cyc = 0;   // negedges since reset release
	int          high_len = 0;
	int          rise_cyc = 0;
	int          last_host_rise = -1;
	logic        e_q = 1'b0;
	logic [9:0]  seen_word;

	task automatic push_pin(input string name, input logic [9:0] word, input int width,
		input bit host);
		pin_name.push_back(name);
		pin_word.push_back(word);
		pin_width.push_back(width);
		pin_host.push_back(host);
	endtask

	// init bytes follow the HD44780 command layout
	task automatic expect_init(input logic [6:0] c);
		push_pin("init_function_set", {6'b000011, c[6], c[5], 2'b00}, cmd_pulse_cycles, 1'b0);
		push_pin("init_on_off", {7'b0000001, c[4], c[3], c[2]}, cmd_pulse_cycles, 1'b0);
		push_pin("init_clear", 10'h001, cmd_pulse_cycles, 1'b0);
		push_pin("init_entry_mode", {8'b00000001, c[1], c[0]}, cmd_pulse_cycles, 1'b0);
	endtask

	task automatic expect_cmd(input string name, input logic [9:0] word);
		push_pin(name, word, pulse_high_cycles, 1'b1);
	endtask

	task automatic expect_write(input string name, input logic [1:0] resp);
		wr_name.push_back(name);
		wr_resp.push_back(resp);
	endtask

	task automatic expect_read(input string name, input logic [1:0] resp, input logic [31:0] data,
		input logic [31:0] mask);
		rd_name.push_back(name);
		rd_resp.push_back(resp);
		rd_data.push_back(data);
		rd_mask.push_back(mask);
	endtask

	function automatic int pulses_pending();
		return pin_name.size();
	endfunction

	task automatic compare(input string name, input string what, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			value_errors++;
			$display("ERR %s %s expected 0x%0h actual 0x%0h", name, what, exp, act);
		end
	endtask

	task automatic end_of_pulse();
		string name;
		if (pin_name.size() == 0) begin
			pulse_errors++;
			$display("unexpected enable pulse carrying 0x%0h", seen_word);
		end else begin
			name = pin_name.pop_front();
			compare(name, "pins", pin_word.pop_front(), seen_word);
			if (high_len != pin_width[0]) begin
				pulse_errors++;
				$display("enable pulse of %s lasted %0d cycles instead of %0d", name, high_len,
					pin_width[0]);
			end
			if (pin_host[0]) begin
				if (last_host_rise >= 0 && rise_cyc - last_host_rise < wait_short_cycles) begin
					pulse_errors++;
					$display("enable of %s rose only %0d cycles after the previous one", name,
						rise_cyc - last_host_rise);
				end
				last_host_rise = rise_cyc;
			end
			void'(pin_width.pop_front());
			void'(pin_host.pop_front());
		end
	endtask

	// sample away from the active edge
	always @(negedge clk) begin
		if (!arst_n) begin
			cyc      = 0;
			e_q      = 1'b0;
			high_len = 0;
			if (e || rs || rw) begin
				pulse_errors++;
				$display("LCD control pins not low during reset");
			end
		end else begin
			cyc++;
			if (cyc <= powerup_cycles && (e || rs || rw)) begin
				pulse_errors++;
				$display("LCD control pins active at cycle %0d, inside the power-up wait", cyc);
			end
			if (e) begin
				if (!e_q)
					rise_cyc = cyc;
				high_len++;
				seen_word = {rs, rw, lcd_data};   // last value before the fall
			end else if (e_q) begin
				end_of_pulse();
				high_len = 0;
			end
			e_q = e;
			if (bvalid && bready) begin
				if (wr_name.size() == 0) begin
					pulse_errors++;
					$display("write response arrived with no write outstanding");
				end else begin
					compare(wr_name.pop_front(), "bresp", wr_resp.pop_front(), bresp);
				end
			end
			if (rvalid && rready) begin
				if (rd_name.size() == 0) begin
					pulse_errors++;
					$display("read data arrived with no read outstanding");
				end else begin
					compare(rd_name[0], "rresp", rd_resp.pop_front(), rresp);
					compare(rd_name.pop_front(), "rdata", rd_data[0] & rd_mask[0],
						rdata & rd_mask[0]);
					void'(rd_data.pop_front());
					void'(rd_mask.pop_front());
				end
			end
		end
	end

	// anything still queued never showed up
	task automatic finish_check();
		if (e_q) begin
			pulse_errors++;
			$display("enable still high when the run ended");
		end
		while (pin_name.size() > 0) begin
			pulse_errors++;
			$display("missing enable pulse for %s", pin_name.pop_front());
		end
		if (wr_name.size() + rd_name.size() > 0) begin
			pulse_errors++;
			$display("%0d bus responses never arrived", wr_name.size() + rd_name.size());
		end
	endtask

endmodule

//--- tb_lcd_top.sv
module tb_lcd_top;

	timeunit 1ns;
	timeprecision 1ps;

	import lcd_regs_pkg::*;
	import lcd_timing_pkg::*;

	typedef enum {op_write, op_read, op_wait_lcd, op_wait_idle} op_e;

	localparam int n_entries = 21;

	logic        clk;
	logic        arst_n;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        e;
	logic        rs;
	logic        rw;
	logic [7:0]  lcd_data;

	string       tbl_name  [n_entries];
	op_e         tbl_op    [n_entries];
	logic [3:0]  tbl_addr  [n_entries];
	logic [31:0] tbl_data  [n_entries];
	logic [1:0]  tbl_resp  [n_entries];
	bit          tbl_reach [n_entries];   // command expected on the pins
	int          n_loaded = 0;
	int          limit = 0;
	int          cycles = 0;

	lcd_subsystem_top DUT (.*);

	tb_lcd_checker u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic add_entry(input string name, input op_e op, input logic [3:0] addr,
		input logic [31:0] data, input logic [1:0] resp, input bit reach);
		tbl_name[n_loaded]  = name;
		tbl_op[n_loaded]    = op;
		tbl_addr[n_loaded]  = addr;
		tbl_data[n_loaded]  = data;
		tbl_resp[n_loaded]  = resp;
		tbl_reach[n_loaded] = reach;
		n_loaded++;
	endtask

	task automatic load_table();
		add_entry("reset_status", op_read, addr_status, 32'h01, axil_resp_okay, 1'b0);
		add_entry("cfg_write", op_write, addr_config, 32'h5a, axil_resp_okay, 1'b0);
		add_entry("cfg_readback", op_read, addr_config, 32'h5a, axil_resp_okay, 1'b0);
		add_entry("wait_init", op_wait_lcd, 4'h0, 32'h0, axil_resp_okay, 1'b0);
		add_entry("init_status", op_read, addr_status, 32'h01, axil_resp_okay, 1'b0);
		add_entry("cmd_0", op_write, addr_cmd, 32'h241, axil_resp_okay, 1'b1);   // rs=1 data
		add_entry("cmd_1", op_write, addr_cmd, 32'h248, axil_resp_okay, 1'b1);
		add_entry("cmd_2", op_write, addr_cmd, 32'h265, axil_resp_okay, 1'b1);
		add_entry("cmd_3", op_write, addr_cmd, 32'h06c, axil_resp_okay, 1'b1);
		add_entry("cmd_4", op_write, addr_cmd, 32'h36f, axil_resp_okay, 1'b1);   // rw set
		add_entry("cmd_5", op_write, addr_cmd, 32'h080, axil_resp_okay, 1'b1);
		add_entry("cmd_6", op_write, addr_cmd, 32'h2c5, axil_resp_okay, 1'b1);
		add_entry("cmd_7", op_write, addr_cmd, 32'h001, axil_resp_okay, 1'b1);
		add_entry("cmd_8", op_write, addr_cmd, 32'h2ff, axil_resp_slverr, 1'b0);  // queue full
		add_entry("cmd_9", op_write, addr_cmd, 32'h300, axil_resp_slverr, 1'b0);
		add_entry("status_full", op_read, addr_status, 32'h81, axil_resp_okay, 1'b0);
		add_entry("status_write", op_write, addr_status, 32'h0, axil_resp_slverr, 1'b0);
		add_entry("unmapped_read", op_read, 4'hc, 32'h0, axil_resp_slverr, 1'b0);
		add_entry("unmapped_write", op_write, 4'hc, 32'h0, axil_resp_slverr, 1'b0);
		add_entry("drain", op_wait_idle, 4'h0, 32'h0, axil_resp_okay, 1'b0);
		add_entry("status_done", op_read, addr_status, 32'h02, axil_resp_okay, 1'b0);
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= 4'hf;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
		do @(negedge clk); while (!(awready && wready));
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do @(negedge clk); while (!bvalid);
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr);
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		do @(negedge clk); while (!rvalid);
		@(posedge clk);
		rready <= 1'b0;
	endtask

	// every expected pulse seen, then the rest of the last command's settle
	task automatic wait_for_drain();
		while (u_checker.pulses_pending() > 0)
			@(posedge clk);
		repeat (wait_short_cycles - setup_cycles - pulse_high_cycles) @(posedge clk);
	endtask

	task automatic apply_entry(input int i);
		case (tbl_op[i])
			op_write: begin
				u_checker.expect_write(tbl_name[i], tbl_resp[i]);
				if (tbl_addr[i] == addr_config)
					u_checker.expect_init(tbl_data[i][6:0]);
				if (tbl_reach[i])
					u_checker.expect_cmd(tbl_name[i], tbl_data[i][9:0]);
				axi_write(tbl_addr[i], tbl_data[i]);
			end
			op_read: begin
				u_checker.expect_read(tbl_name[i], tbl_resp[i], tbl_data[i], 32'hffff_ffff);
				axi_read(tbl_addr[i]);
			end
			op_wait_lcd: do @(negedge clk); while (!e);   // first init pulse
			default: wait_for_drain();
		endcase
	endtask

	initial begin : stimulus
		int i;
		int total;
		arst_n  = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		load_table();
		total = 0;
		for (i = 0; i < n_loaded; i++)
			total += tbl_reach[i];
		limit = powerup_cycles + 4 * cmd_pulse_cycles + 2 * wait_short_cycles
			+ wait_clear_cycles + wait_entry_cycles + total * wait_short_cycles + 2000;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		for (i = 0; i < n_loaded; i++)
			apply_entry(i);
		u_checker.finish_check();
		total = u_checker.value_errors + u_checker.pulse_errors;
		$display("errors: value %0d, pulse %0d, total %0d", u_checker.value_errors,
			u_checker.pulse_errors, total);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : watchdog
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("errors: value %0d, pulse %0d", u_checker.value_errors, u_checker.pulse_errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- compile.f
lcd_timing_pkg.sv
lcd_regs_pkg.sv
lcd_axil_regs.sv
lcd_cmd_fifo.sv
lcd_hd44780_ctrl.sv
lcd_subsystem_top.sv
tb_lcd_checker.sv
tb_lcd_top.sv

//--- Bender.yml
package:
  name: lcd_subsystem

sources:
  - lcd_timing_pkg.sv
  - lcd_regs_pkg.sv
  - lcd_axil_regs.sv
  - lcd_cmd_fifo.sv
  - lcd_hd44780_ctrl.sv
  - lcd_subsystem_top.sv
  - target: test
    files:
      - tb_lcd_checker.sv
      - tb_lcd_top.sv
